//--- src/isaPkg.sv
// instruction set constants for the single-cycle MIPS subset
// field widths, opcode and funct codes; imported by the core and the testbench
`default_nettype none

package isaPkg;

  // ==========================================================================
  // field widths
  // ==========================================================================
  localparam int dataWidth      = 32;
  localparam int regAddrWidth   = 5;
  localparam int immWidth       = 16;
  localparam int jumpFieldWidth = 26;
  // data memory is 128 words
  localparam int memAddrWidth   = 7;
  localparam int opWidth        = 6;
  localparam int fnWidth        = 6;

  // ==========================================================================
  // opcodes, instr[31:26]
  // ==========================================================================
  localparam logic [opWidth-1:0] opR   = 6'h00;
  localparam logic [opWidth-1:0] opLw  = 6'h23;
  localparam logic [opWidth-1:0] opSw  = 6'h2b;
  localparam logic [opWidth-1:0] opBeq = 6'h04;
  localparam logic [opWidth-1:0] opJ   = 6'h02;
  localparam logic [opWidth-1:0] opJal = 6'h03;

  // funct codes, only meaningful with opR
  localparam logic [fnWidth-1:0] fnAdd = 6'h20;
  localparam logic [fnWidth-1:0] fnSub = 6'h22;
  localparam logic [fnWidth-1:0] fnAnd = 6'h24;
  localparam logic [fnWidth-1:0] fnOr  = 6'h25;
  localparam logic [fnWidth-1:0] fnSlt = 6'h2a;

  // return address register for jal
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

endpackage

`default_nettype wire

//--- src/ctrlPkg.sv
// control encodings shared by decode and execute
// ALU operation codes and the coarse operation class out of the main decoder
`default_nettype none

package ctrlPkg;

  // class chosen from the opcode alone
  typedef enum logic [1:0] {
    // lw and sw address add
    memAddr = 2'b00,
    // beq subtract for equality
    compare = 2'b01,
    // operation taken from funct
    rType   = 2'b10
  } aluOpClass;

  // ==========================================================================
  // resolved ALU operation
  // ==========================================================================
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110,
    aluSlt = 4'b0111,
    // unsupported funct, result forced to zero
    aluBad = 4'b1111
  } aluCtrl;

endpackage

`default_nettype wire

//--- src/controlUnit.sv
// main decoder of the single-cycle core
// opcode and funct in, datapath control levels and the resolved ALU op out
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; (
  input  logic [opWidth-1:0] opcode,
  input  logic [fnWidth-1:0] funct,
  output logic               regDst,
  output logic               aluSrc,
  output logic               memToReg,
  output logic               regWrite,
  output logic               memWrite,
  output logic               branch,
  output logic               jump,
  output logic               link,
  output aluCtrl             aluOp
);

  aluOpClass opClass;

  // ==========================================================================
  // opcode decode
  // ==========================================================================
  always_comb begin
    // everything off unless the opcode says otherwise
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    opClass  = memAddr;
    case (opcode)
      opR: begin
        // rd destination, funct picks the op
        regDst   = 1'b1;
        regWrite = 1'b1;
        opClass  = rType;
      end
      opLw: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // rs - rt, zero flag decides
        branch  = 1'b1;
        opClass = compare;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // writes pc+8 into linkReg
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unknown opcode behaves as a nop
        opClass = memAddr;
      end
    endcase
  end

  // class plus funct to one alu code
  always_comb begin
    case (opClass)
      memAddr: aluOp = aluAdd;
      compare: aluOp = aluSub;
      rType: begin
        case (funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          default: aluOp = aluBad;
        endcase
      end
      default: aluOp = aluBad;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu.sv
// 32-bit ALU for the execute stage
// add, sub, and, or and unsigned set-less-than, with a zero flag for beq
`timescale 1ns/1ps
`default_nettype none

module alu import isaPkg::*, ctrlPkg::*; (
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  aluCtrl               op,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  // ==========================================================================
  // operation select
  // ==========================================================================
  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // unsigned compare, one in bit 0
      aluSlt: result = (a < b) ? {{(dataWidth-1){1'b0}}, 1'b1} : '0;
      // aluBad and anything else
      default: result = '0;
    endcase
  end

  // set for any op, only branch logic looks at it
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/regFile.sv
// general purpose register file, 32 x 32
// two combinational read ports, one write port on the rising clock edge
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    writeEn,
  input  logic [regAddrWidth-1:0] readAddrA,
  input  logic [regAddrWidth-1:0] readAddrB,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData,
  output logic [dataWidth-1:0]    readDataA,
  output logic [dataWidth-1:0]    readDataB
);

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // ==========================================================================
  // write port
  // ==========================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared on reset
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // r0 is hardwired, writes dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ==========================================================================
  // read ports
  // ==========================================================================
  // no write-through, new value visible next cycle
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- src/pcUnit.sv
// program counter and next-address logic
// jump has priority over a taken branch, else sequential pc+4
`timescale 1ns/1ps
`default_nettype none

module pcUnit import isaPkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      branch,
  input  logic                      zero,
  input  logic                      jump,
  input  logic [immWidth-1:0]       immediate,
  input  logic [jumpFieldWidth-1:0] jumpField,
  output logic [dataWidth-1:0]      pc,
  output logic [dataWidth-1:0]      pcPlus8
);

  // bits of pc+4 kept on top of a jump target
  localparam int regionWidth = dataWidth - jumpFieldWidth - 2;

  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] pcNext;

  assign pcPlus4 = pc + 32'd4;
  // jal return value
  assign pcPlus8 = pc + 32'd8;

  // ==========================================================================
  // target computation
  // ==========================================================================
  // word offset, sign extended then times four
  assign immExt       = {{(dataWidth-immWidth){immediate[immWidth-1]}}, immediate};
  assign branchTarget = pcPlus4 + {immExt[dataWidth-3:0], 2'b00};
  assign jumpTarget   = {pcPlus4[dataWidth-1 -: regionWidth], jumpField, 2'b00};

  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // one instruction per cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
// single-cycle MIPS core top level, memories live outside
// fetch, decode, execute and write-back all settle within one clock cycle
`timescale 1ns/1ps
`default_nettype none

module mipsCore import isaPkg::*, ctrlPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  output logic [dataWidth-1:0]    instrAddr,
  input  logic [dataWidth-1:0]    instr,
  output logic [memAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]    memWdata,
  output logic                    memWen,
  input  logic [dataWidth-1:0]    memRdata,
  output logic [dataWidth-1:0]    rfWriteData
);

  // instruction fields
  logic [opWidth-1:0]        opcode;
  logic [fnWidth-1:0]        funct;
  logic [regAddrWidth-1:0]   rs;
  logic [regAddrWidth-1:0]   rt;
  logic [regAddrWidth-1:0]   rd;
  logic [immWidth-1:0]       imm;
  logic [jumpFieldWidth-1:0] jumpField;

  // decode outputs
  logic   regDst;
  logic   aluSrc;
  logic   memToReg;
  logic   regWrite;
  logic   memWrite;
  logic   branch;
  logic   jump;
  logic   link;
  aluCtrl aluOp;

  // datapath
  logic [dataWidth-1:0]    readDataA;
  logic [dataWidth-1:0]    readDataB;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    aluB;
  logic [dataWidth-1:0]    aluResult;
  logic                    aluZero;
  logic [regAddrWidth-1:0] writeReg;
  logic [dataWidth-1:0]    pcPlus8;

  // ==========================================================================
  // field split
  // ==========================================================================
  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign funct     = instr[fnWidth-1:0];
  assign imm       = instr[immWidth-1:0];
  assign jumpField = instr[jumpFieldWidth-1:0];

  pcUnit uPc (
    .clk       (clk),
    .rst       (rst),
    .branch    (branch),
    .zero      (aluZero),
    .jump      (jump),
    .immediate (imm),
    .jumpField (jumpField),
    .pc        (instrAddr),
    .pcPlus8   (pcPlus8)
  );

  controlUnit uCtrl (
    .opcode   (opcode),
    .funct    (funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluOp)
  );

  regFile uRegs (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (regWrite),
    .readAddrA (rs),
    .readAddrB (rt),
    .writeAddr (writeReg),
    .writeData (rfWriteData),
    .readDataA (readDataA),
    .readDataB (readDataB)
  );

  alu uAlu (
    .a      (readDataA),
    .b      (aluB),
    .op     (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ==========================================================================
  // selects
  // ==========================================================================
  // jal overrides the rt/rd choice
  assign writeReg = link ? linkReg : (regDst ? rd : rt);

  // immediate only for lw/sw address
  assign immExt = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
  assign aluB   = aluSrc ? immExt : readDataB;

  // write-back: return address, load data or alu result
  always_comb begin
    if (link) begin
      rfWriteData = pcPlus8;
    end else if (memToReg) begin
      rfWriteData = memRdata;
    end else begin
      rfWriteData = aluResult;
    end
  end

  // data memory side, word address straight from the alu
  assign memAddr  = aluResult[memAddrWidth-1:0];
  assign memWdata = readDataB;
  // active low write strobe
  assign memWen   = !memWrite;

endmodule

`default_nettype wire

//--- testbench/mipsCore_properties.sv
// bound checks on pc sequencing and the data memory write strobe
// attached to every mipsCore instance by the bind at the bottom
`timescale 1ns/1ps
`default_nettype none

module mipsCoreProperties import isaPkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic [dataWidth-1:0] instrAddr,
  input logic [dataWidth-1:0] instr,
  input logic                 memWen
);

  logic [opWidth-1:0] opcode;
  logic               flowChange;
  // failed assertion count, read by the testbench
  int                 failCount = 0;

  assign opcode     = instr[31:26];
  // beq, j and jal may leave the pc+4 path
  assign flowChange = (opcode == opBeq) || (opcode == opJ) || (opcode == opJal);

  // ==========================================================================
  // pc
  // ==========================================================================
  // held at zero through reset and the first cycle after
  resetPc: assert property (@(posedge clk) !rst |=> (instrAddr == '0))
    else begin
      failCount++;
      $error("instrAddr left zero while reset was active");
    end

  // the edge that releases reset still holds pc at zero
  sequentialPc: assert property (@(posedge clk) disable iff (!rst)
    (rst && !flowChange) |=> (instrAddr == $past(instrAddr) + 32'd4))
    else begin
      failCount++;
      $error("instrAddr did not advance by four after a sequential instruction");
    end

  // ==========================================================================
  // write strobe
  // ==========================================================================
  // low exactly for sw
  writeStrobe: assert property (@(posedge clk) disable iff (!rst)
    memWen == (opcode != opSw))
    else begin
      failCount++;
      $error("memWen does not match the store opcode");
    end

endmodule

bind mipsCore mipsCoreProperties uProps (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .instr     (instr),
  .memWen    (memWen)
);

`default_nettype wire

//--- testbench/tbMips.sv
// testbench for the single-cycle MIPS core
// models both memories, runs a fixed program on random operands, checks against a shadow model
`timescale 1ns/1ps
`default_nettype none

module tbMips import isaPkg::*, ctrlPkg::*; ();

  localparam int progWords   = 28;
  localparam int resetCycles = 16;
  // program words plus reset plus slack, 20 ns each
  localparam int watchdogNs  = (progWords + resetCycles + 20) * 20;
  localparam logic [31:0] randomSeed = 32'h62ab;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [6:0]  memAddr;
  logic [31:0] memWdata;
  logic        memWen;
  logic [31:0] memRdata;
  logic [31:0] rfWriteData;

  logic [31:0] imem [64];
  logic [31:0] dmem [128];
  // shadow state
  logic [31:0] sReg [32];
  logic [31:0] sMem [128];

  // retire info from the negedge check, applied at the next rising edge
  logic        pendRegEn;
  logic [4:0]  pendReg;
  logic [31:0] pendRegVal;
  logic        pendMemEn;
  logic [6:0]  pendMemAddr;
  logic [31:0] pendMemVal;
  logic [31:0] expPc;
  logic [31:0] finalJump;

  mipsCore DUT (
    .clk         (clk),
    .rst         (rst),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .memAddr     (memAddr),
    .memWdata    (memWdata),
    .memWen      (memWen),
    .memRdata    (memRdata),
    .rfWriteData (rfWriteData)
  );

  // both memories read asynchronously
  assign instr    = imem[instrAddr[7:2]];
  assign memRdata = dmem[memAddr];

  always #10 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  function automatic logic [31:0] signExt(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic stopRun();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("Mismatch %s: expected %h, got %h", name, expected, actual);
      stopRun();
    end
  endtask

  // ==========================================================================
  // memories, program and reset
  // ==========================================================================
  initial begin
    clk = 1'b0;
    rst <= 1'b0;
    void'($urandom(randomSeed));
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'd0;
    end
    // fill pattern built from the full word address
    for (int i = 0; i < 128; i++) begin
      dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'h3c};
    end
    // operand words for r1..r4
    for (int i = 1; i <= 4; i++) begin
      dmem[i] = $urandom;
    end
    for (int i = 0; i < 128; i++) begin
      sMem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      sReg[i] = 32'd0;
    end
    imem[1]  = encI(opLw, 5'd1, 5'd0, 16'd1);
    imem[2]  = encI(opLw, 5'd2, 5'd0, 16'd2);
    imem[3]  = encI(opLw, 5'd3, 5'd0, 16'd3);
    imem[4]  = encI(opLw, 5'd4, 5'd0, 16'd4);
    imem[5]  = encR(fnAdd, 5'd5, 5'd1, 5'd2);
    imem[6]  = encR(fnSub, 5'd6, 5'd1, 5'd2);
    imem[7]  = encR(fnAnd, 5'd7, 5'd3, 5'd4);
    imem[8]  = encR(fnOr, 5'd8, 5'd3, 5'd4);
    imem[9]  = encR(fnSlt, 5'd9, 5'd1, 5'd2);
    imem[10] = encR(fnSlt, 5'd10, 5'd2, 5'd1);
    imem[11] = encI(opSw, 5'd5, 5'd0, 16'd20);
    // base is the slt result, 0 or 1
    imem[12] = encI(opSw, 5'd6, 5'd9, 16'd21);
    imem[13] = encI(opLw, 5'd11, 5'd0, 16'd20);
    imem[14] = encI(opLw, 5'd12, 5'd9, 16'd21);
    // taken, skips word 16
    imem[15] = encI(opBeq, 5'd5, 5'd11, 16'd1);
    imem[16] = encR(fnAdd, 5'd13, 5'd1, 5'd1);
    // equal only if r2 happens to be zero
    imem[17] = encI(opBeq, 5'd5, 5'd1, 16'd1);
    imem[18] = encR(fnAdd, 5'd14, 5'd1, 5'd0);
    imem[19] = encJ(opJal, 26'd22);
    imem[20] = encR(fnAdd, 5'd15, 5'd31, 5'd0);
    imem[22] = encR(fnOr, 5'd16, 5'd31, 5'd0);
    imem[23] = encJ(opJ, 26'd25);
    imem[24] = encR(fnAdd, 5'd13, 5'd2, 5'd2);
    imem[25] = encI(opSw, 5'd31, 5'd0, 16'd30);
    imem[26] = encI(opLw, 5'd17, 5'd0, 16'd30);
    // jump to self ends the program
    imem[27] = encJ(opJ, 26'd27);
    finalJump = imem[27];
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
  end

  // watchdog
  initial begin
    #(watchdogNs);
    $display("Timeout: the program never reached its final jump");
    stopRun();
  end

  // data memory write and shadow retire
  always @(posedge clk) begin
    if (!memWen) begin
      dmem[memAddr] <= memWdata;
    end
    if (pendRegEn && (pendReg != 5'd0)) begin
      sReg[pendReg] = pendRegVal;
    end
    if (pendMemEn) begin
      sMem[pendMemAddr] = pendMemVal;
    end
  end

  // ==========================================================================
  // mid-cycle checks
  // ==========================================================================
  always @(negedge clk) begin
    logic [5:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ext;
    logic [31:0] sum;
    logic [31:0] pc4;
    logic [31:0] result;
    logic [6:0]  addr;
    // bound assertions on the core fired at the last rising edge
    if (DUT.uProps.failCount != 0) begin
      $display("A bound assertion on the core failed");
      stopRun();
    end
    op        = instr[31:26];
    pendRegEn = 1'b0;
    pendMemEn = 1'b0;
    if (!rst) begin
      // pc parked, no write strobe
      checkValue("instrAddr", 32'd0, instrAddr);
      checkValue("memWen", 32'd1, {31'd0, memWen});
      expPc = 32'd0;
    end else begin
      checkValue("instrAddr", expPc, instrAddr);
      checkValue("memWen", {31'd0, op != opSw}, {31'd0, memWen});
      a      = sReg[instr[25:21]];
      b      = sReg[instr[20:16]];
      ext    = signExt(instr[15:0]);
      sum    = a + ext;
      addr   = sum[6:0];
      pc4    = instrAddr + 32'd4;
      expPc  = pc4;
      result = 32'd0;
      case (op)
        opR: begin
          pendRegEn = 1'b1;
          case (instr[5:0])
            fnAdd: result = a + b;
            fnSub: result = a - b;
            fnAnd: result = a & b;
            fnOr:  result = a | b;
            fnSlt: result = (a < b) ? 32'd1 : 32'd0;
            // nop and unknown funct left unchecked
            default: pendRegEn = 1'b0;
          endcase
          if (pendRegEn) begin
            checkValue("rfWriteData", result, rfWriteData);
          end
          pendReg    = instr[15:11];
          pendRegVal = result;
        end
        opLw: begin
          checkValue("memAddr", {25'd0, addr}, {25'd0, memAddr});
          checkValue("rfWriteData", sMem[addr], rfWriteData);
          pendRegEn  = 1'b1;
          pendReg    = instr[20:16];
          pendRegVal = sMem[addr];
        end
        opSw: begin
          checkValue("memAddr", {25'd0, addr}, {25'd0, memAddr});
          checkValue("memWdata", b, memWdata);
          pendMemEn   = 1'b1;
          pendMemAddr = addr;
          pendMemVal  = b;
        end
        opBeq: begin
          if (a == b) begin
            expPc = pc4 + {ext[29:0], 2'b00};
          end
        end
        opJ: begin
          expPc = {pc4[31:28], instr[25:0], 2'b00};
        end
        opJal: begin
          expPc = {pc4[31:28], instr[25:0], 2'b00};
          checkValue("rfWriteData", instrAddr + 32'd8, rfWriteData);
          pendRegEn  = 1'b1;
          pendReg    = 5'd31;
          pendRegVal = instrAddr + 32'd8;
        end
        default: begin
          pendRegEn = 1'b0;
        end
      endcase
      if (instr == finalJump) begin
        $display("ALL TESTS PASSED");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- flist.f
src/isaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/mipsCore.sv
testbench/mipsCore_properties.sv
testbench/tbMips.sv

//--- run.sh
#!/bin/sh
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tbMips -f flist.f -o simMips \
  && ./obj_dir/simMips | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
